// ==== Makefile ====
# Verilator flow for the decimating FIR testbench

VERILATOR ?= verilator
TOP ?= firDecimatorTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test OK

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Status follows the search for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/firDecimatorTb.sv ====
`timescale 1ns/1ps

module firDecimatorTb;

    localparam int Lookahead = 16;
    localparam int Lookback = 16;
    localparam int Dsr = 8;
    localparam int LutSize = 4;
    localparam int WindowWidth = Lookahead + Lookback;
    localparam int Msb = firTypesPkg::OutWidth - 1;
    localparam int ResetCycles = 10;
    localparam int WaitLimit = 1000;
    localparam int StallCycles = 150;
    localparam int RandomBits = 2000;
    localparam int MinStallRun = 16;

    logic clkDS;
    logic rstN;
    logic sampleIn;
    logic sampleValid;
    logic sampleReady;
    firTypesPkg::outWordT outWord;
    logic outValid;
    logic outReady;

    logic [WindowWidth-1:0] modelWindow;
    int modelCount;
    int accepted;
    int received;
    int valueErrors;
    int otherErrors;
    int readyLowRun;
    bit timedOut;
    bit stallOut;
    bit sawInputStall;
    firTypesPkg::outWordT expectedQ [$];
    firTypesPkg::outWordT want;
    firTypesPkg::outWordT lastWord;

    firDecimator #(
        .Lookahead(Lookahead),
        .Lookback(Lookback),
        .Dsr(Dsr),
        .LutSize(LutSize)
    ) DUT (
        .clkDS(clkDS),
        .rstN(rstN),
        .sampleIn(sampleIn),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .outWord(outWord),
        .outValid(outValid),
        .outReady(outReady)
    );

    initial begin
        clkDS = 1'b0;
        forever #2 clkDS = ~clkDS;
    end

    // Lookahead taps run in reversed age order, lookback taps start at age Lookahead
    function automatic firTypesPkg::outWordT expectedWord(logic [WindowWidth-1:0] win);
        int total;
        int scaled;
        int satHigh;
        total = 0;
        satHigh = (1 << Msb) - 1;
        for (int j = 0; j < Lookahead; j++) begin
            if (win[Lookahead-1-j]) begin
                total += int'(firCoeffPkg::hbCoeff[j]);
            end
        end
        for (int k = 0; k < Lookback; k++) begin
            if (win[Lookahead+k]) begin
                total += int'(firCoeffPkg::hfCoeff[k]);
            end
        end
        scaled = total >>> firCoeffPkg::ScaleShift;
        if (scaled > satHigh) begin
            scaled = satHigh;
        end else if (scaled < -satHigh - 1) begin
            scaled = -satHigh - 1;
        end
        return {~scaled[Msb], scaled[Msb-1:0]};
    endfunction

    function automatic void recordAccept(logic b);
        modelWindow = {modelWindow[WindowWidth-2:0], b};
        accepted++;
        modelCount++;
        if (modelCount == Dsr) begin
            modelCount = 0;
            expectedQ.push_back(expectedWord(modelWindow));
        end
    endfunction

    task automatic checkResetState();
        if (outValid !== 1'b0) begin
            valueErrors++;
            $display("Fail at %0t: outValid expected 0, got %b", $time, outValid);
        end
        if (sampleReady !== 1'b1) begin
            valueErrors++;
            $display("Fail at %0t: sampleReady expected 1, got %b", $time, sampleReady);
        end
    endtask

    task automatic idleCycle();
        @(posedge clkDS);
        sampleValid <= 1'b0;
    endtask

    // Offer one bit, model takes it once the handshake is certain
    task automatic sendBit(input logic b);
        int waitCycles;
        if (timedOut) begin
            return;
        end
        @(posedge clkDS);
        sampleIn <= b;
        sampleValid <= 1'b1;
        waitCycles = 0;
        @(negedge clkDS);
        while (!sampleReady && !timedOut) begin
            waitCycles++;
            if (waitCycles > WaitLimit) begin
                timedOut = 1'b1;
                otherErrors++;
                $display("Timeout at %0t: sampleReady stayed low for %0d cycles",
                         $time, WaitLimit);
            end else begin
                @(negedge clkDS);
            end
        end
        if (!timedOut) begin
            recordAccept(b);
        end
    endtask

    task automatic sendStream(input int count, input bit randomBits, input logic level);
        logic b;
        for (int i = 0; i < count; i++) begin
            if ($urandom % 4 == 0) begin
                idleCycle();
            end
            b = randomBits ? 1'($urandom) : level;
            sendBit(b);
        end
        idleCycle();
    endtask

    // Output side back-pressure
    always @(posedge clkDS) begin
        outReady <= stallOut ? 1'b0 : ($urandom % 4 != 0);
    end

    // Transfer happens on the next rising edge; outWord is stable here
    always @(negedge clkDS) begin
        if (rstN && outValid && outReady) begin
            if (expectedQ.size() == 0) begin
                otherErrors++;
                $display("Error at %0t: an output word %h arrived with none expected",
                         $time, outWord);
            end else begin
                want = expectedQ.pop_front();
                if (outWord !== want) begin
                    valueErrors++;
                    $display("Fail at %0t: outWord expected %h, got %h", $time, want, outWord);
                end
            end
            received++;
            lastWord = outWord;
        end
        // A released window alone drops ready for one cycle only
        if (stallOut && !sampleReady) begin
            readyLowRun++;
            if (readyLowRun > MinStallRun) begin
                sawInputStall = 1'b1;
            end
        end else begin
            readyLowRun = 0;
        end
    end

    initial begin
        int waitCycles;
        void'($urandom(32'hc200_339b));
        rstN = 1'b0;
        sampleIn = 1'b0;
        sampleValid = 1'b0;
        outReady = 1'b0;
        stallOut = 1'b0;
        sawInputStall = 1'b0;
        timedOut = 1'b0;
        modelWindow = '0;
        modelCount = 0;
        accepted = 0;
        received = 0;
        valueErrors = 0;
        otherErrors = 0;
        readyLowRun = 0;
        lastWord = '0;

        for (int i = 1; i < ResetCycles; i++) begin
            @(negedge clkDS);
            checkResetState();
        end
        @(posedge clkDS);
        rstN <= 1'b1;
        repeat (2) begin
            @(negedge clkDS);
            checkResetState();
        end

        // Impulse, then random, all ones, stalls and all zeros
        sendBit(1'b1);
        sendStream(39, 1'b0, 1'b0);
        sendStream(RandomBits, 1'b1, 1'b0);
        sendStream(64, 1'b0, 1'b1);

        for (int s = 0; s < 2; s++) begin
            sawInputStall = 1'b0;
            fork
                sendStream(240, 1'b1, 1'b0);
                begin
                    @(negedge clkDS);
                    stallOut <= 1'b1;
                    repeat (StallCycles) @(negedge clkDS);
                    stallOut <= 1'b0;
                end
            join
            if (!sawInputStall && !timedOut) begin
                otherErrors++;
                $display("Error at %0t: sampleReady never fell while outReady was held low",
                         $time);
            end
        end

        sendStream(64, 1'b0, 1'b0);

        waitCycles = 0;
        while (received < accepted / Dsr && !timedOut) begin
            waitCycles++;
            if (waitCycles > WaitLimit) begin
                timedOut = 1'b1;
                otherErrors++;
                $display("Timeout at %0t: waiting for %0d outputs, %0d arrived",
                         $time, accepted / Dsr, received);
            end else begin
                @(negedge clkDS);
            end
        end
        // Catch any late duplicate
        repeat (20) @(negedge clkDS);

        if (received != accepted / Dsr) begin
            valueErrors++;
            $display("Fail at %0t: output count expected %0d, got %0d",
                     $time, accepted / Dsr, received);
        end
        // Zero window maps to mid-scale
        if (lastWord !== 12'h800) begin
            valueErrors++;
            $display("Fail at %0t: outWord expected 800, got %h", $time, lastWord);
        end

        $display("Errors: %0d value mismatches, %0d other failures, %0d outputs checked",
                 valueErrors, otherErrors, received);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== common/firCoeffPkg.sv ====
package firCoeffPkg;

    // Lookahead taps, index 0 sits next to the filter center
    localparam firTypesPkg::coeffT hbCoeff [firTypesPkg::MaxTaps] = '{
        1200, 1150, 1060, 940, 800, 650, 500, 360,
        230, 120, 30, -40, -90, -120, -130, -125,
        -110, -90, -65, -40, -20, -5, 8, 16,
        20, 20, 18, 14, 10, 6, 3, 1
    };

    // Lookback taps, slightly asymmetric to the lookahead side
    localparam firTypesPkg::coeffT hfCoeff [firTypesPkg::MaxTaps] = '{
        1180, 1120, 1030, 900, 760, 610, 460, 320,
        200, 95, 10, -55, -100, -125, -132, -124,
        -106, -84, -60, -36, -16, -2, 10, 17,
        20, 19, 16, 12, 8, 5, 2, 1
    };

    // From 13 to 11 fraction bits
    localparam int ScaleShift = 2;

    // Limits of a signed output word before the MSB flip
    localparam logic signed [firTypesPkg::OutWidth-1:0] SatMax =
        {1'b0, {(firTypesPkg::OutWidth - 1){1'b1}}};
    localparam logic signed [firTypesPkg::OutWidth-1:0] SatMin =
        {1'b1, {(firTypesPkg::OutWidth - 1){1'b0}}};

endpackage

// ==== common/firTypesPkg.sv ====
package firTypesPkg;

    // Coefficients are Q1.13
    localparam int CoeffWidth = 14;

    // Wide enough for any sum of MaxTaps coefficients
    localparam int AccWidth = 20;

    localparam int OutWidth = 12;

    // Largest supported half length
    localparam int MaxTaps = 32;

    typedef logic signed [CoeffWidth-1:0] coeffT;

    // Partial sums and half-sums
    typedef logic signed [AccWidth-1:0] accT;

    // Sum of both halves, one guard bit more
    typedef logic signed [AccWidth:0] totalT;

    // Offset binary output word
    typedef logic [OutWidth-1:0] outWordT;

endpackage

// ==== common/partialSumIf.sv ====
`timescale 1ns/1ps

interface partialSumIf;

    firTypesPkg::accT aheadSum;
    firTypesPkg::accT backSum;
    logic sumValid;
    logic sumReady;

    modport producer (
        output aheadSum,
        output backSum,
        output sumValid,
        input  sumReady
    );

    modport consumer (
        input  aheadSum,
        input  backSum,
        input  sumValid,
        output sumReady
    );

endinterface

// ==== hw/firDecimator.sv ====
`timescale 1ns/1ps

module firDecimator #(
    parameter int Lookahead = 16,
    parameter int Lookback = 16,
    parameter int Dsr = 8,
    parameter int LutSize = 4
) (
    input  logic clkDS,
    input  logic rstN,
    input  logic sampleIn,
    input  logic sampleValid,
    output logic sampleReady,
    output firTypesPkg::outWordT outWord,
    output logic outValid,
    input  logic outReady
);

    logic [Lookahead+Lookback-1:0] window;
    logic windowValid;
    logic windowReady;

    partialSumIf sumsIf ();

    // Window is released every Dsr accepted bits
    sampleGather #(
        .Lookahead(Lookahead),
        .Lookback(Lookback),
        .Dsr(Dsr)
    ) gather (
        .clkDS(clkDS),
        .rstN(rstN),
        .sampleIn(sampleIn),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .window(window),
        .windowValid(windowValid),
        .windowReady(windowReady)
    );

    dualLutMac #(
        .Lookahead(Lookahead),
        .Lookback(Lookback),
        .LutSize(LutSize)
    ) mac (
        .clkDS(clkDS),
        .rstN(rstN),
        .window(window),
        .windowValid(windowValid),
        .windowReady(windowReady),
        .sums(sumsIf.producer)
    );

    outputFormatter formatter (
        .clkDS(clkDS),
        .rstN(rstN),
        .sums(sumsIf.consumer),
        .outWord(outWord),
        .outValid(outValid),
        .outReady(outReady)
    );

endmodule

// ==== hw/outputFormatter.sv ====
`timescale 1ns/1ps

module outputFormatter (
    input  logic clkDS,
    input  logic rstN,
    partialSumIf.consumer sums,
    output firTypesPkg::outWordT outWord,
    output logic outValid,
    input  logic outReady
);

    localparam int Msb = firTypesPkg::OutWidth - 1;

    firTypesPkg::totalT total;
    firTypesPkg::totalT scaled;
    logic signed [Msb:0] clipped;
    firTypesPkg::outWordT formatted;
    logic take;

    assign sums.sumReady = !outValid || outReady;
    assign take = sums.sumValid && sums.sumReady;

    assign total = firTypesPkg::totalT'(sums.aheadSum) + firTypesPkg::totalT'(sums.backSum);
    // Truncating shift toward minus infinity
    assign scaled = total >>> firCoeffPkg::ScaleShift;

    always_comb begin
        if (scaled > firCoeffPkg::SatMax) begin
            clipped = firCoeffPkg::SatMax;
        end else if (scaled < firCoeffPkg::SatMin) begin
            clipped = firCoeffPkg::SatMin;
        end else begin
            clipped = scaled[Msb:0];
        end
    end

    // Offset binary
    assign formatted = {~clipped[Msb], clipped[Msb-1:0]};

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (take) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clkDS) begin
        if (take) begin
            outWord <= formatted;
        end
    end

    outHeld: assert property (
        @(posedge clkDS) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outWord)
    );

endmodule

// ==== hw/sampleGather.sv ====
`timescale 1ns/1ps

module sampleGather #(
    parameter int Lookahead = 16,
    parameter int Lookback = 16,
    parameter int Dsr = 8
) (
    input  logic clkDS,
    input  logic rstN,
    input  logic sampleIn,
    input  logic sampleValid,
    output logic sampleReady,
    output logic [Lookahead+Lookback-1:0] window,
    output logic windowValid,
    input  logic windowReady
);

    localparam int WindowWidth = Lookahead + Lookback;
    localparam int CntWidth = (Dsr > 1) ? $clog2(Dsr) : 1;
    localparam logic [CntWidth-1:0] LastCount = CntWidth'(Dsr - 1);

    logic [WindowWidth-1:0] windowReg;
    logic [CntWidth-1:0] count;
    logic accept;

    // Frozen while a released window waits
    assign sampleReady = !windowValid;
    assign accept = sampleValid && sampleReady;
    assign window = windowReg;

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            windowReg <= '0;
            count <= '0;
            windowValid <= 1'b0;
        end else begin
            if (accept) begin
                // Newest sample enters at bit 0
                windowReg <= {windowReg[WindowWidth-2:0], sampleIn};
                if (count == LastCount) begin
                    count <= '0;
                    windowValid <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
            if (windowValid && windowReady) begin
                windowValid <= 1'b0;
            end
        end
    end

    // Released window must wait unchanged for its consumer
    windowHeld: assert property (
        @(posedge clkDS) disable iff (!rstN)
        windowValid && !windowReady |=> windowValid && $stable(window)
    );

endmodule

// ==== lutMac/dualLutMac.sv ====
`timescale 1ns/1ps

module dualLutMac #(
    parameter int Lookahead = 16,
    parameter int Lookback = 16,
    parameter int LutSize = 4
) (
    input  logic clkDS,
    input  logic rstN,
    input  logic [Lookahead+Lookback-1:0] window,
    input  logic windowValid,
    output logic windowReady,
    partialSumIf.producer sums
);

    localparam int AheadGroups = (Lookahead + LutSize - 1) / LutSize;
    localparam int BackGroups = (Lookback + LutSize - 1) / LutSize;
    localparam int MaxGroups = (AheadGroups > BackGroups) ? AheadGroups : BackGroups;
    // Both trees share one depth so the halves stay aligned
    localparam int Depth = $clog2(MaxGroups);

    logic [Lookahead-1:0] aheadTaps;
    logic [Lookback-1:0] backTaps;
    logic [Depth:0] validPipe;
    logic enable;

    // Lookahead half in reversed age order
    for (genvar j = 0; j < Lookahead; j++) begin : rev
        assign aheadTaps[j] = window[Lookahead-1-j];
    end

    assign backTaps = window[Lookahead+Lookback-1:Lookahead];

    // Whole pipeline holds only on a blocked result
    assign enable = !(sums.sumValid && !sums.sumReady);
    assign windowReady = enable;

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            validPipe <= '0;
        end else if (enable) begin
            validPipe[0] <= windowValid;
            for (int i = 1; i <= Depth; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    assign sums.sumValid = validPipe[Depth];

    lutMacUnit #(
        .Taps(Lookahead),
        .LutSize(LutSize),
        .Depth(Depth),
        .UseLookback(1'b0)
    ) aheadUnit (
        .clkDS(clkDS),
        .enable(enable),
        .taps(aheadTaps),
        .sum(sums.aheadSum)
    );

    lutMacUnit #(
        .Taps(Lookback),
        .LutSize(LutSize),
        .Depth(Depth),
        .UseLookback(1'b1)
    ) backUnit (
        .clkDS(clkDS),
        .enable(enable),
        .taps(backTaps),
        .sum(sums.backSum)
    );

    sumsHeld: assert property (
        @(posedge clkDS) disable iff (!rstN)
        sums.sumValid && !sums.sumReady |=>
            sums.sumValid && $stable(sums.aheadSum) && $stable(sums.backSum)
    );

endmodule

// ==== lutMac/lutMacUnit.sv ====
`timescale 1ns/1ps

module lutMacUnit #(
    parameter int Taps = 16,
    parameter int LutSize = 4,
    parameter int Depth = 2,
    parameter bit UseLookback = 1'b0
) (
    input  logic clkDS,
    input  logic enable,
    input  logic [Taps-1:0] taps,
    output firTypesPkg::accT sum
);

    localparam int Groups = (Taps + LutSize - 1) / LutSize;
    localparam int Entries = 1 << LutSize;
    localparam int PadWidth = Groups * LutSize;

    // Sum of the coefficients selected by the set bits of sel
    function automatic firTypesPkg::accT entrySum(int group, int sel);
        firTypesPkg::accT acc;
        int idx;
        acc = '0;
        for (int b = 0; b < LutSize; b++) begin
            idx = group * LutSize + b;
            if (idx < Taps && sel[b]) begin
                if (UseLookback) begin
                    acc = acc + firCoeffPkg::hfCoeff[idx];
                end else begin
                    acc = acc + firCoeffPkg::hbCoeff[idx];
                end
            end
        end
        return acc;
    endfunction

    // Nodes left at a given tree level
    function automatic int nodeCount(int level);
        int n;
        n = Groups;
        for (int l = 0; l < level; l++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    logic [PadWidth-1:0] padded;
    firTypesPkg::accT tree [Depth+1][Groups];

    // Unused top bits of the last group read as zero
    assign padded = PadWidth'(taps);

    for (genvar g = 0; g < Groups; g++) begin : grp
        firTypesPkg::accT lut [Entries];
        logic [LutSize-1:0] sel;

        for (genvar e = 0; e < Entries; e++) begin : ent
            localparam firTypesPkg::accT Entry = entrySum(g, e);
            assign lut[e] = Entry;
        end

        assign sel = padded[g*LutSize +: LutSize];

        always_ff @(posedge clkDS) begin
            if (enable) begin
                tree[0][g] <= lut[sel];
            end
        end
    end

    // Odd node passes through; a shallow tree just forwards its root
    for (genvar l = 1; l <= Depth; l++) begin : lvl
        for (genvar n = 0; n < nodeCount(l); n++) begin : node
            if (2 * n + 1 < nodeCount(l - 1)) begin : pair
                always_ff @(posedge clkDS) begin
                    if (enable) begin
                        tree[l][n] <= tree[l-1][2*n] + tree[l-1][2*n+1];
                    end
                end
            end else begin : single
                always_ff @(posedge clkDS) begin
                    if (enable) begin
                        tree[l][n] <= tree[l-1][2*n];
                    end
                end
            end
        end
    end

    assign sum = tree[Depth][0];

endmodule

// ==== tb.f ====
common/firTypesPkg.sv
common/firCoeffPkg.sv
common/partialSumIf.sv
hw/sampleGather.sv
lutMac/lutMacUnit.sv
lutMac/dualLutMac.sv
hw/outputFormatter.sv
hw/firDecimator.sv
bench/firDecimatorTb.sv
